// ==== rtl/fetch_buffer.sv ====
`timescale 1ns/10ps
`default_nettype none

module fetch_buffer (
  input  wire logic                      clock,
  input  wire logic                      arst_n,
  input  wire fetch_pkg::fetch_packet_s  packet,
  input  wire logic                      dispatch_en,
  input  wire logic                      rollback_en,
  output logic                           fetch_en,
  output fetch_pkg::fetch_entry_s        inst_out,
  output logic                           inst_out_valid
);

  fetch_pkg::fetch_entry_s                                  fifo_q [fetch_pkg::fb_depth];
  logic [fetch_pkg::fb_ptr_w-1:0]                           head_q;
  logic [fetch_pkg::fb_ptr_w-1:0]                           tail_q;
  logic [fetch_pkg::fb_cnt_w-1:0]                           count_q;

  logic [fetch_pkg::num_super-1:0]                          wr_slot;
  logic [fetch_pkg::num_super-1:0][fetch_pkg::fb_ptr_w-1:0] wr_ptr;
  logic [fetch_pkg::fb_ptr_w-1:0]                           next_tail;
  logic [fetch_pkg::fb_cnt_w-1:0]                           n_wr;
  logic                                                     pop;

  ////////////////////////////////////////////////////////////////////////////
  // write side
  ////////////////////////////////////////////////////////////////////////////

  // valid slots pack in slot order from the tail
  always_comb begin
    next_tail = tail_q;
    n_wr      = '0;
    for (int i = 0; i < fetch_pkg::num_super; i++) begin
      // writes on a rollback edge are dropped
      wr_slot[i] = packet.valid[i] && !rollback_en;
      wr_ptr[i]  = next_tail;
      if (wr_slot[i]) begin
        next_tail = next_tail + 1'b1;
        n_wr      = n_wr + 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    for (int i = 0; i < fetch_pkg::num_super; i++) begin
      if (wr_slot[i]) begin
        fifo_q[wr_ptr[i]] <= packet.entry[i];
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // pointers and count
  ////////////////////////////////////////////////////////////////////////////

  assign pop = dispatch_en && inst_out_valid;

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
    end else if (rollback_en) begin
      // flush
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
    end else begin
      if (pop) begin
        head_q <= head_q + 1'b1;
      end
      tail_q  <= next_tail;
      count_q <= count_q + n_wr - {{fetch_pkg::fb_ptr_w{1'b0}}, pop};
    end
  end

  // head entry straight from the ring
  assign inst_out       = fifo_q[head_q];
  assign inst_out_valid = (count_q != '0);

  // fetch only with room for a whole packet
  assign fetch_en = (count_q <= fetch_pkg::fb_max_fill);

endmodule

`default_nettype wire

// ==== rtl/fetch_frontend.sv ====
`timescale 1ns/10ps
`default_nettype none

module fetch_frontend (
  input  wire logic                              clock,
  input  wire logic                              arst_n,
  input  wire mem_bus_pkg::mem_rsp_s             mem2proc,
  output mem_bus_pkg::mem_req_s                  proc2mem,
  input  wire logic                              dispatch_en,
  input  wire logic                              rollback_en,
  input  wire logic [mem_bus_pkg::addr_w-1:0]    redirect_pc,
  output fetch_pkg::fetch_entry_s                inst_out,
  output logic                                   inst_out_valid
);

  logic [mem_bus_pkg::addr_w-1:0]   fetch_addr;
  fetch_pkg::inst_block_u           block;
  logic                             block_valid;
  fetch_pkg::fetch_packet_s         packet;
  logic                             fetch_en;

  // cache and miss controller, owns the memory bus
  icache icache_0 (
    .clock       (clock),
    .arst_n      (arst_n),
    .mem2proc    (mem2proc),
    .proc2mem    (proc2mem),
    .fetch_addr  (fetch_addr),
    .block       (block),
    .block_valid (block_valid)
  );

  fetch_stage fetch_stage_0 (
    .clock       (clock),
    .arst_n      (arst_n),
    .block       (block),
    .block_valid (block_valid),
    .fetch_en    (fetch_en),
    .rollback_en (rollback_en),
    .redirect_pc (redirect_pc),
    .fetch_addr  (fetch_addr),
    .packet      (packet)
  );

  // queue toward dispatch
  fetch_buffer fetch_buffer_0 (
    .clock          (clock),
    .arst_n         (arst_n),
    .packet         (packet),
    .dispatch_en    (dispatch_en),
    .rollback_en    (rollback_en),
    .fetch_en       (fetch_en),
    .inst_out       (inst_out),
    .inst_out_valid (inst_out_valid)
  );

endmodule

`default_nettype wire

// ==== rtl/fetch_pkg.sv ====
`default_nettype none

package fetch_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // fetch width and cache geometry
  ////////////////////////////////////////////////////////////////////////////

  localparam int num_super   = 2;
  localparam int inst_w      = 32;
  localparam int inst_bytes  = inst_w / 8;

  // one cache line holds one fetch block
  localparam int offset_w    = 3;
  localparam int block_bytes = 1 << offset_w;
  localparam int index_w     = 5;
  localparam int num_lines   = 1 << index_w;

  // tag covers address bits 15:8, 64 KiB space
  localparam int ctag_w      = 8;

  // fetch buffer
  localparam int fb_depth    = 8;
  localparam int fb_ptr_w    = 3;
  localparam int fb_cnt_w    = fb_ptr_w + 1;

  // highest count that still leaves room for a full packet
  localparam logic [fb_cnt_w-1:0] fb_max_fill = fb_cnt_w'(fb_depth - num_super);

  ////////////////////////////////////////////////////////////////////////////
  // block and packet types
  ////////////////////////////////////////////////////////////////////////////

  // cache keeps raw bus words, fetch reads them as slots
  // slot 0 sits in the low half
  typedef union packed {
    logic [mem_bus_pkg::data_w-1:0]     raw;
    logic [num_super-1:0][inst_w-1:0]   slot;
  } inst_block_u;

  typedef struct packed {
    logic [inst_w-1:0]                  inst;
    logic [mem_bus_pkg::addr_w-1:0]     pc;
  } fetch_entry_s;

  typedef struct packed {
    fetch_entry_s [num_super-1:0]       entry;
    logic [num_super-1:0]               valid;
  } fetch_packet_s;

  // line fill from the miss controller
  typedef struct packed {
    logic                               wr_en;
    logic [index_w-1:0]                 wr_idx;
    logic [ctag_w-1:0]                  wr_tag;
    inst_block_u                        data;
  } cache_fill_s;

endpackage

`default_nettype wire

// ==== rtl/fetch_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module fetch_stage (
  input  wire logic                              clock,
  input  wire logic                              arst_n,
  input  wire fetch_pkg::inst_block_u            block,
  input  wire logic                              block_valid,
  input  wire logic                              fetch_en,
  input  wire logic                              rollback_en,
  input  wire logic [mem_bus_pkg::addr_w-1:0]    redirect_pc,
  output logic [mem_bus_pkg::addr_w-1:0]         fetch_addr,
  output fetch_pkg::fetch_packet_s               packet
);

  logic [mem_bus_pkg::addr_w-1:0]           pc_q;
  logic [mem_bus_pkg::addr_w-1:0]           block_base;
  logic [fetch_pkg::offset_w-3:0]           start_slot;
  logic                                     fire;

  // a block is taken only with room in the buffer and no redirect
  assign fire = block_valid && fetch_en && !rollback_en;

  assign block_base = {
    pc_q[mem_bus_pkg::addr_w-1:fetch_pkg::offset_w],
    {fetch_pkg::offset_w{1'b0}}
  };

  // first slot the pc points into
  assign start_slot = pc_q[fetch_pkg::offset_w-1:2];

  assign fetch_addr = pc_q;

  ////////////////////////////////////////////////////////////////////////////
  // slot split
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    for (int i = 0; i < fetch_pkg::num_super; i++) begin
      packet.entry[i].inst = block.slot[i];
      packet.entry[i].pc   = block_base + (i * fetch_pkg::inst_bytes);
      // slots below a mid-block redirect target are dropped
      packet.valid[i]      = fire && (i >= start_slot);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // pc register
  ////////////////////////////////////////////////////////////////////////////

  // stalls hold the pc, rollback wins over a fetched block
  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      pc_q <= '0;
    end else if (rollback_en) begin
      pc_q <= redirect_pc;
    end else if (fire) begin
      pc_q <= block_base + fetch_pkg::block_bytes;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/icache.sv ====
`timescale 1ns/10ps
`default_nettype none

module icache (
  input  wire logic                              clock,
  input  wire logic                              arst_n,
  input  wire mem_bus_pkg::mem_rsp_s             mem2proc,
  output mem_bus_pkg::mem_req_s                  proc2mem,
  input  wire logic [mem_bus_pkg::addr_w-1:0]    fetch_addr,
  output fetch_pkg::inst_block_u                 block,
  output logic                                   block_valid
);

  logic [fetch_pkg::index_w-1:0]    rd_idx;
  logic [fetch_pkg::ctag_w-1:0]     rd_tag;
  logic                             rd_valid;
  fetch_pkg::inst_block_u           rd_data;
  fetch_pkg::cache_fill_s           fill;

  logic                             req_valid_q;
  logic                             pending_q;
  logic [mem_bus_pkg::tag_w-1:0]    pend_tag_q;
  logic [fetch_pkg::index_w-1:0]    miss_idx_q;
  logic [fetch_pkg::ctag_w-1:0]     miss_tag_q;

  logic                             start_miss;
  logic                             accepted;
  logic                             returned;

  // address split, bits above the tag are ignored
  assign rd_idx = fetch_addr[fetch_pkg::offset_w +: fetch_pkg::index_w];
  assign rd_tag = fetch_addr[fetch_pkg::offset_w + fetch_pkg::index_w +: fetch_pkg::ctag_w];

  icache_mem cache_mem_0 (
    .clock    (clock),
    .arst_n   (arst_n),
    .fill     (fill),
    .rd_idx   (rd_idx),
    .rd_tag   (rd_tag),
    .rd_data  (rd_data),
    .rd_valid (rd_valid)
  );

  assign block       = rd_data;
  assign block_valid = rd_valid;

  ////////////////////////////////////////////////////////////////////////////
  // miss request and tag tracking
  ////////////////////////////////////////////////////////////////////////////

  // only one miss in flight
  assign start_miss = !rd_valid && !req_valid_q && !pending_q;
  assign accepted   = req_valid_q && (mem2proc.response != '0);
  assign returned   = pending_q && (mem2proc.tag == pend_tag_q);

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      req_valid_q <= 1'b0;
      pending_q   <= 1'b0;
      pend_tag_q  <= '0;
    end else begin
      if (start_miss) begin
        req_valid_q <= 1'b1;
      end else if (accepted) begin
        req_valid_q <= 1'b0;
      end
      // response value becomes the tag to wait for
      if (accepted) begin
        pending_q  <= 1'b1;
        pend_tag_q <= mem2proc.response;
      end else if (returned) begin
        pending_q  <= 1'b0;
      end
    end
  end

  // line of the missing block, kept until its fill
  always_ff @(posedge clock) begin
    if (start_miss) begin
      miss_idx_q <= rd_idx;
      miss_tag_q <= rd_tag;
    end
  end

  // load is rebuilt from the saved line, block aligned
  always_comb begin
    proc2mem.command = mem_bus_pkg::bus_none;
    proc2mem.addr    = '0;
    if (req_valid_q) begin
      proc2mem.command = mem_bus_pkg::bus_load;
      proc2mem.addr    = {
        {(mem_bus_pkg::addr_w - fetch_pkg::ctag_w - fetch_pkg::index_w
          - fetch_pkg::offset_w){1'b0}},
        miss_tag_q,
        miss_idx_q,
        {fetch_pkg::offset_w{1'b0}}
      };
    end
  end

  // fill goes to the line of the request, not the current address
  assign fill.wr_en    = returned;
  assign fill.wr_idx   = miss_idx_q;
  assign fill.wr_tag   = miss_tag_q;
  assign fill.data.raw = mem2proc.data;

endmodule

`default_nettype wire

// ==== rtl/icache_mem.sv ====
`timescale 1ns/10ps
`default_nettype none

module icache_mem (
  input  wire logic                          clock,
  input  wire logic                          arst_n,
  input  wire fetch_pkg::cache_fill_s        fill,
  input  wire logic [fetch_pkg::index_w-1:0] rd_idx,
  input  wire logic [fetch_pkg::ctag_w-1:0]  rd_tag,
  output fetch_pkg::inst_block_u             rd_data,
  output logic                               rd_valid
);

  logic [fetch_pkg::num_lines-1:0]  valid_q;
  logic [fetch_pkg::ctag_w-1:0]     tag_q  [fetch_pkg::num_lines];
  fetch_pkg::inst_block_u           data_q [fetch_pkg::num_lines];

  // all lines start out empty
  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      valid_q <= '0;
    end else if (fill.wr_en) begin
      valid_q[fill.wr_idx] <= 1'b1;
    end
  end

  // tag and data arrays
  always_ff @(posedge clock) begin
    if (fill.wr_en) begin
      tag_q[fill.wr_idx]  <= fill.wr_tag;
      data_q[fill.wr_idx] <= fill.data;
    end
  end

  // combinational lookup
  assign rd_data  = data_q[rd_idx];
  assign rd_valid = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);

endmodule

`default_nettype wire

// ==== rtl/mem_bus_pkg.sv ====
`default_nettype none

package mem_bus_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // bus widths
  ////////////////////////////////////////////////////////////////////////////

  localparam int addr_w = 64;
  localparam int data_w = 64;

  // zero on response or tag means no transaction
  localparam int tag_w  = 4;

  ////////////////////////////////////////////////////////////////////////////
  // command encoding
  ////////////////////////////////////////////////////////////////////////////

  // store is never issued by the fetch side
  typedef enum logic [1:0] {
    bus_none  = 2'h0,
    bus_load  = 2'h1,
    bus_store = 2'h2
  } bus_cmd_e;

  // processor to memory
  typedef struct packed {
    bus_cmd_e            command;
    logic [addr_w-1:0]   addr;
  } mem_req_s;

  // memory to processor
  // response tags the request being accepted, tag marks returning data
  typedef struct packed {
    logic [tag_w-1:0]    response;
    logic [data_w-1:0]   data;
    logic [tag_w-1:0]    tag;
  } mem_rsp_s;

endpackage

`default_nettype wire

// ==== src.f ====
rtl/mem_bus_pkg.sv
rtl/fetch_pkg.sv
rtl/icache_mem.sv
rtl/icache.sv
rtl/fetch_stage.sv
rtl/fetch_buffer.sv
rtl/fetch_frontend.sv
verification/fetch_frontend_assertions.sv
verification/tb_fetch_frontend.sv

// ==== verification/fetch_frontend_assertions.sv ====
`timescale 1ns/10ps
`default_nettype none

module fetch_frontend_assertions (
  input  wire logic                        clock,
  input  wire logic                        arst_n,
  input  wire mem_bus_pkg::mem_req_s       proc2mem,
  input  wire mem_bus_pkg::mem_rsp_s       mem2proc,
  input  wire logic                        dispatch_en,
  input  wire logic                        rollback_en,
  input  wire fetch_pkg::fetch_entry_s     inst_out,
  input  wire logic                        inst_out_valid
);

  logic                             load_offered;
  logic                             tag_pending;
  logic [mem_bus_pkg::tag_w-1:0]    pending_tag;

  logic reset_failed   = 1'b0;
  logic hold_failed    = 1'b0;
  logic align_failed   = 1'b0;
  logic overlap_failed = 1'b0;
  logic stall_failed   = 1'b0;
  logic any_failed;

  assign load_offered = (proc2mem.command == mem_bus_pkg::bus_load);
  assign any_failed   = reset_failed | hold_failed | align_failed | overlap_failed | stall_failed;

  // bus side view of the outstanding tag
  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      tag_pending <= 1'b0;
      pending_tag <= '0;
    end else if (load_offered && (mem2proc.response != '0)) begin
      tag_pending <= 1'b1;
      pending_tag <= mem2proc.response;
    end else if (tag_pending && (mem2proc.tag == pending_tag)) begin
      tag_pending <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // bus protocol
  ////////////////////////////////////////////////////////////////////////////

  reset_idle: assert property (@(posedge clock)
    !arst_n |-> (proc2mem.command == mem_bus_pkg::bus_none) && !inst_out_valid)
    else begin
      reset_failed = 1'b1;
      $error("bus command or instruction output active during reset");
    end

  // refused load stays on the bus unchanged
  load_hold: assert property (@(posedge clock) disable iff (!arst_n)
    load_offered && (mem2proc.response == '0) |=> load_offered && $stable(proc2mem.addr))
    else begin
      hold_failed = 1'b1;
      $error("refused load was not held with the same address");
    end

  load_aligned: assert property (@(posedge clock) disable iff (!arst_n)
    load_offered |-> (proc2mem.addr[fetch_pkg::offset_w-1:0] == '0))
    else begin
      align_failed = 1'b1;
      $error("load address not block aligned");
    end

  single_miss: assert property (@(posedge clock) disable iff (!arst_n)
    tag_pending |-> !load_offered)
    else begin
      overlap_failed = 1'b1;
      $error("new load offered while a tag is pending");
    end

  ////////////////////////////////////////////////////////////////////////////
  // dispatch side
  ////////////////////////////////////////////////////////////////////////////

  head_stable: assert property (@(posedge clock) disable iff (!arst_n)
    inst_out_valid && !dispatch_en && !rollback_en |=> inst_out_valid && $stable(inst_out))
    else begin
      stall_failed = 1'b1;
      $error("head instruction changed while not dispatched");
    end

endmodule

bind fetch_frontend fetch_frontend_assertions checks_0 (
  .clock          (clock),
  .arst_n         (arst_n),
  .proc2mem       (proc2mem),
  .mem2proc       (mem2proc),
  .dispatch_en    (dispatch_en),
  .rollback_en    (rollback_en),
  .inst_out       (inst_out),
  .inst_out_valid (inst_out_valid)
);

`default_nettype wire

// ==== verification/tb_fetch_frontend.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_fetch_frontend;

  localparam int          clk_period   = 40;
  localparam int          reset_cycles = 10;
  localparam int          num_pops     = 3000;
  localparam int          max_cycles   = 200_000;
  localparam logic [31:0] rng_seed     = 32'h284b_9510;
  localparam int          num_blocks   = 8192;

  // stream stays in one 256-byte window, one block per cache line
  localparam int          win_bytes    = 256;
  localparam int          win_limit    = 192;
  localparam int          target_span  = 160;

  logic                              clock;
  logic                              arst_n;
  mem_bus_pkg::mem_rsp_s             mem2proc;
  mem_bus_pkg::mem_req_s             proc2mem;
  logic                              dispatch_en;
  logic                              rollback_en;
  logic [mem_bus_pkg::addr_w-1:0]    redirect_pc;
  fetch_pkg::fetch_entry_s           inst_out;
  logic                              inst_out_valid;

  // memory model
  logic [num_blocks-1:0]             filled;
  logic                              mem_busy;
  logic [mem_bus_pkg::tag_w-1:0]     mem_tag;
  logic [mem_bus_pkg::addr_w-1:0]    mem_addr;
  int                                mem_wait;

  // stream tracking
  logic [mem_bus_pkg::addr_w-1:0]    win_base;
  logic [mem_bus_pkg::addr_w-1:0]    next_pc;
  logic                              after_redirect;
  logic                              started;
  int                                stall_left;
  int                                pop_count;

  fetch_frontend UUT (
    .clock          (clock),
    .arst_n         (arst_n),
    .mem2proc       (mem2proc),
    .proc2mem       (proc2mem),
    .dispatch_en    (dispatch_en),
    .rollback_en    (rollback_en),
    .redirect_pc    (redirect_pc),
    .inst_out       (inst_out),
    .inst_out_valid (inst_out_valid)
  );

  initial begin
    clock = 1'b0;
    forever #(clk_period / 2) clock = ~clock;
  end

  initial begin
    #(clk_period * max_cycles);
    $display("watchdog expired after %0d cycles, %0d of %0d instructions popped",
             max_cycles, pop_count, num_pops);
    $display("Result: FAILED");
    $fatal(1, "simulation timed out");
  end

  ////////////////////////////////////////////////////////////////////////////
  // reference and reporting
  ////////////////////////////////////////////////////////////////////////////

  // slot 0 in the low half, each word the inverse of its own address
  function automatic logic [63:0] block_word(input logic [63:0] addr);
    logic [63:0] hi_addr;
    hi_addr = addr + 64'd4;
    return {~hi_addr[31:0], ~addr[31:0]};
  endfunction

  task automatic report_mismatch(input string test, input logic [63:0] expected,
                                 input logic [63:0] actual);
    $display("CHECK FAILED %s: expected %h, actual %h", test, expected, actual);
    $display("Result: FAILED");
    $fatal(1, "mismatch in %s", test);
  endtask

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("Result: FAILED");
    $fatal(1, "%s", what);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // stimulus, all on the falling edge
  ////////////////////////////////////////////////////////////////////////////

  // tagged memory, one load at a time, 1 to 8 cycles to return
  task automatic drive_memory();
    mem2proc.response = '0;
    mem2proc.tag      = '0;
    if (mem_busy) begin
      mem_wait--;
      if (mem_wait == 0) begin
        mem2proc.tag  = mem_tag;
        mem2proc.data = block_word(mem_addr);
        filled[mem_addr[15:3]] = 1'b1;
        mem_busy = 1'b0;
      end
    end
    if ((proc2mem.command == mem_bus_pkg::bus_load) && !mem_busy) begin
      assert (!filled[proc2mem.addr[15:3]])
        else report_failure($sformatf("load issued for block %h that is already cached",
                                      proc2mem.addr));
      // one in four offers is refused
      if ($urandom % 4 != 0) begin
        mem_tag  = 4'(1 + $urandom % 15);
        mem_wait = 1 + int'($urandom % 8);
        mem_addr = proc2mem.addr;
        mem_busy = 1'b1;
        mem2proc.response = mem_tag;
      end
    end
  endtask

  task automatic check_pop();
    string stream_check;
    if (after_redirect && redirect_pc[2])
      stream_check = "redirect alignment";
    else if (after_redirect)
      stream_check = "redirect target";
    else
      stream_check = "in-order stream";
    assert (inst_out.pc == next_pc)
      else report_mismatch(stream_check, next_pc, inst_out.pc);
    assert (inst_out.inst == ~next_pc[31:0])
      else report_mismatch("instruction word", {32'h0, ~next_pc[31:0]},
                           {32'h0, inst_out.inst});
    next_pc        = next_pc + 64'd4;
    after_redirect = 1'b0;
    pop_count++;
  endtask

  task automatic drive_front_end();
    logic roll;
    roll = 1'b0;
    if (!started)
      roll = 1'b1;
    else if (inst_out_valid && (inst_out.pc >= win_base + win_limit))
      roll = 1'b1;
    else if ($urandom % 40 == 0)
      roll = 1'b1;
    // occasional long stalls fill the buffer
    if (stall_left > 0)
      stall_left--;
    else if ($urandom % 100 == 0)
      stall_left = 10 + int'($urandom % 30);
    dispatch_en = (stall_left == 0) && ($urandom % 3 != 0);
    rollback_en = roll;
    if (roll) begin
      redirect_pc    = win_base + 4 * ($urandom % (target_span / 4));
      next_pc        = redirect_pc;
      after_redirect = 1'b1;
      started        = 1'b1;
    end
    if (dispatch_en && inst_out_valid && !roll) begin
      check_pop();
    end
  endtask

  task automatic stop_on_assertion();
    $display("a bound bus or dispatch assertion failed");
    $display("Result: FAILED");
    $fatal(1, "bound assertion failure");
  endtask

  initial begin
    void'($urandom(rng_seed));
    arst_n         = 1'b0;
    dispatch_en    = 1'b0;
    rollback_en    = 1'b0;
    redirect_pc    = '0;
    mem2proc       = '0;
    filled         = '0;
    mem_busy       = 1'b0;
    mem_tag        = '0;
    mem_addr       = '0;
    mem_wait       = 0;
    next_pc        = '0;
    after_redirect = 1'b0;
    started        = 1'b0;
    stall_left     = 0;
    pop_count      = 0;
    // window away from the reset pc
    win_base = (1 + $urandom % 255) * win_bytes;
    repeat (reset_cycles) @(posedge clock);
    @(negedge clock);
    arst_n = 1'b1;
    while (pop_count < num_pops) begin
      @(negedge clock);
      drive_memory();
      drive_front_end();
      if (UUT.checks_0.any_failed) begin
        stop_on_assertion();
      end
    end
    @(negedge clock);
    if (!UUT.checks_0.any_failed) begin
      $display("Result: PASSED");
      $finish;
    end else begin
      $display("Result: FAILED");
      $fatal(1, "bound assertion failure at end of run");
    end
  end

endmodule

`default_nettype wire
